// File: hw/exec_defines.svh
// execute back end widths, zero-register id, pairing bit and memory hold limit
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// data path width
`define EXEC_XLEN 64

// register id width, top bit marks paired / high registers
`define EXEC_GPR_W 7

// bit of a register id that flags a paired or high register
`define EXEC_GPR_PAIR_BIT 6

// zero register, writing it means no write at all
`define EXEC_GPR_ZZR 7'h00

// hold cycles in a row that are still tolerated before a fault
`define EXEC_HOLD_LIMIT 12

// hold counter width, counter saturates at all ones
`define EXEC_HOLD_CNT_W 4

`endif

// File: hw/execPkg.sv
// execPkg: register id, stage command, load format and memory status types
`include "exec_defines.svh"

package execPkg;

	// register id, bit 6 set for paired / high regs
	typedef logic [`EXEC_GPR_W-1:0] gprId_t;

	// stage command as seen by EX3
	typedef enum logic [2:0] {
		UCMD_NOP       = 3'd0,	// nothing
		UCMD_ALU       = 3'd1,	// result already forwarded from EX1/EX2
		UCMD_STORE     = 3'd2,	// memory op, no register write
		UCMD_LOAD      = 3'd3,	// load, result ready now
		UCMD_LOAD_HELD = 3'd4,	// load written through the held port
		UCMD_MUL3      = 3'd5	// multiply, late result
	} uCmd_t;

	// load narrowing / extension format
	typedef enum logic [2:0] {
		LDFMT_Q   = 3'd0,	// full 64
		LDFMT_L   = 3'd1,	// signed 32
		LDFMT_UL  = 3'd2,	// unsigned 32
		LDFMT_W   = 3'd3,	// signed 16
		LDFMT_UW  = 3'd4,	// unsigned 16
		LDFMT_B   = 3'd5,	// signed 8
		LDFMT_UB  = 3'd6,	// unsigned 8
		LDFMT_T48 = 3'd7	// signed 48
	} loadFmt_t;

	// data cache status, code 01 reads as ready
	typedef enum logic [1:0] {
		MEMOK_READY = 2'b00,
		MEMOK_HOLD  = 2'b10,
		MEMOK_FAULT = 2'b11
	} memOk_t;

endpackage

// File: hw/loadExtend.sv
// loadExtend: narrows raw load data to the load format and sign or zero extends it
`timescale 1ns/1ps
`include "exec_defines.svh"

module loadExtend
	import execPkg::*;
(
	input  logic [`EXEC_XLEN-1:0] memDataIn,	// raw word from the data cache
	input  loadFmt_t              opLdFmt,
	output logic [`EXEC_XLEN-1:0] ldValue
);

	// sign bits of each narrow field
	logic sign8;
	logic sign16;
	logic sign32;
	logic sign48;

	assign sign8  = memDataIn[7];
	assign sign16 = memDataIn[15];
	assign sign32 = memDataIn[31];
	assign sign48 = memDataIn[47];

	always_comb begin
		ldValue = memDataIn;	// Q passes through
		case (opLdFmt)
			LDFMT_Q: begin
				ldValue = memDataIn;
			end
			LDFMT_L: begin
				ldValue = {{(`EXEC_XLEN-32){sign32}}, memDataIn[31:0]};
			end
			LDFMT_UL: begin
				ldValue = {{(`EXEC_XLEN-32){1'b0}}, memDataIn[31:0]};
			end
			LDFMT_W: begin
				ldValue = {{(`EXEC_XLEN-16){sign16}}, memDataIn[15:0]};
			end
			LDFMT_UW: begin
				ldValue = {{(`EXEC_XLEN-16){1'b0}}, memDataIn[15:0]};
			end
			LDFMT_B: begin
				ldValue = {{(`EXEC_XLEN-8){sign8}}, memDataIn[7:0]};
			end
			LDFMT_UB: begin
				ldValue = {{(`EXEC_XLEN-8){1'b0}}, memDataIn[7:0]};
			end
			LDFMT_T48: begin
				// 48-bit pointer style load, always signed
				ldValue = {{(`EXEC_XLEN-48){sign48}}, memDataIn[47:0]};
			end
			default: begin
				ldValue = memDataIn;
			end
		endcase
	end

endmodule

// File: hw/holdTimer.sv
// holdTimer: saturating count of consecutive memory hold cycles with a limit flag
`timescale 1ns/1ps
`include "exec_defines.svh"

module holdTimer (
	input  logic clock,
	input  logic reset,
	input  logic holdRun,		// high while the wait FSM sits in WAIT
	output logic holdExpired	// count reached the tolerated limit
);

	localparam logic [`EXEC_HOLD_CNT_W-1:0] cntMax = '1;	// saturation point, 15
	localparam logic [`EXEC_HOLD_CNT_W-1:0] cntLimit = `EXEC_HOLD_LIMIT;

	logic [`EXEC_HOLD_CNT_W-1:0] holdCnt;

	always_ff @(posedge clock) begin
		if (reset) begin
			holdCnt <= '0;
		end else if (!holdRun) begin
			holdCnt <= '0;	// any break in the hold restarts the count
		end else if (holdCnt != cntMax) begin
			holdCnt <= holdCnt + 1'b1;
		end
	end

	// zero-cycle flag straight off the counter
	assign holdExpired = (holdCnt >= cntLimit);

endmodule

// File: hw/memWaitFsm.sv
// memWaitFsm: memory wait FSM driving the stage stall level and the sticky fault
`timescale 1ns/1ps

module memWaitFsm
	import execPkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   memOp,		// stage holds a load or store
	input  memOk_t memDataOK,	// status from the data cache
	input  logic   holdExpired,	// from holdTimer
	output logic   exHold,		// stall, same cycle
	output logic   memFault,	// sticky until reset
	output logic   holdRun		// count enable for holdTimer
);

	typedef enum logic [1:0] {
		stRun     = 2'd0,
		stWait    = 2'd1,
		stFaulted = 2'd2
	} waitState_t;

	waitState_t state;
	waitState_t stateNext;

	// status decode, 01 falls through as ready
	logic okHold;
	logic okFault;

	assign okHold  = (memDataOK == MEMOK_HOLD);
	assign okFault = (memDataOK == MEMOK_FAULT);

	always_comb begin
		stateNext = state;
		case (state)
			stRun: begin
				if (memOp && okFault)
					stateNext = stFaulted;
				else if (memOp && okHold)
					stateNext = stWait;	// first hold cycle
			end
			stWait: begin
				if ((memOp && okFault) || holdExpired)
					stateNext = stFaulted;	// hard fault or held too long
				else if (!okHold)
					stateNext = stRun;	// cache came back
			end
			stFaulted: begin
				stateNext = stFaulted;	// only reset leaves
			end
			default: begin
				stateNext = stRun;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= stRun;
		else
			state <= stateNext;
	end

	// stall only while a live memory op sees hold
	assign exHold   = memOp && okHold && (state != stFaulted);
	assign holdRun  = (state == stWait);
	assign memFault = (state == stFaulted);

endmodule

// File: hw/exStage3.sv
// exStage3: third execute stage, picks fast and held writes and registers them
`timescale 1ns/1ps
`include "exec_defines.svh"

module exStage3
	import execPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  uCmd_t                 opUCmd,
	input  logic                  opBraFlush,	// branch flush, cancels writes
	input  gprId_t                regIdRn1,		// dest forwarded from EX1/EX2
	input  logic [`EXEC_XLEN-1:0] regValRn1,
	input  gprId_t                regIdRm,		// load / multiply destination
	input  logic [`EXEC_XLEN-1:0] regValMulRes,
	input  logic [`EXEC_XLEN-1:0] ldValue,		// extended load data
	input  logic                  exHold,		// stall from the wait FSM
	input  logic                  memFault,		// sticky memory fault
	output logic                  memOp,
	output gprId_t                regIdRn2,		// fast port
	output logic [`EXEC_XLEN-1:0] regValRn2,
	output gprId_t                regIdRn4,		// held port
	output logic [`EXEC_XLEN-1:0] regValRn4
);

	// next-cycle write values
	gprId_t                nextIdRn2;
	logic [`EXEC_XLEN-1:0] nextValRn2;
	gprId_t                nextIdRn4;
	logic [`EXEC_XLEN-1:0] nextValRn4;

	// result selection
	logic [`EXEC_XLEN-1:0] valOutDfl;
	logic [`EXEC_XLEN-1:0] valOutHeld;
	logic                  doOutDfl;
	logic                  doOutHeld;
	logic                  killWrite;

	assign killWrite = opBraFlush || exHold || memFault;

	always_comb begin
		valOutDfl  = '0;
		valOutHeld = '0;
		doOutDfl   = 1'b0;
		doOutHeld  = 1'b0;
		memOp      = 1'b0;

		case (opUCmd)
			UCMD_STORE: begin
				memOp = 1'b1;	// nothing to write back
			end
			UCMD_LOAD: begin
				memOp     = 1'b1;
				valOutDfl = ldValue;
				doOutDfl  = 1'b1;
			end
			UCMD_LOAD_HELD: begin
				memOp      = 1'b1;
				valOutHeld = ldValue;
				// paired / high dest handled elsewhere, keep the forward
				doOutHeld  = !regIdRm[`EXEC_GPR_PAIR_BIT];
			end
			UCMD_MUL3: begin
				valOutHeld = regValMulRes;
				doOutHeld  = 1'b1;
			end
			default: begin
				// NOP and ALU just forward
			end
		endcase
	end

	always_comb begin
		nextIdRn2  = regIdRn1;	// forward by default
		nextValRn2 = regValRn1;
		nextIdRn4  = regIdRn1;
		nextValRn4 = regValRn1;

		if (doOutHeld) begin
			nextIdRn2  = regIdRm;	// reserve the dest, value comes later
			nextValRn2 = '0;
			nextIdRn4  = regIdRm;
			nextValRn4 = valOutHeld;
		end

		if (doOutDfl) begin
			nextIdRn2  = regIdRm;
			nextValRn2 = valOutDfl;
			nextIdRn4  = regIdRm;
			nextValRn4 = valOutDfl;
		end

		// flush, stall bubble or dead memory, no writes
		if (killWrite) begin
			nextIdRn2 = `EXEC_GPR_ZZR;
			nextIdRn4 = `EXEC_GPR_ZZR;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			regIdRn2  <= `EXEC_GPR_ZZR;
			regValRn2 <= '0;
			regIdRn4  <= `EXEC_GPR_ZZR;
			regValRn4 <= '0;
		end else begin
			regIdRn2  <= nextIdRn2;
			regValRn2 <= nextValRn2;
			regIdRn4  <= nextIdRn4;
			regValRn4 <= nextValRn4;
		end
	end

endmodule

// File: hw/execTail.sv
// execTail: execute back end top with stage 3, load extender, wait FSM and hold timer
`timescale 1ns/1ps
`include "exec_defines.svh"

module execTail
	import execPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  uCmd_t                 opUCmd,
	input  loadFmt_t              opLdFmt,
	input  logic                  opBraFlush,
	input  gprId_t                regIdRn1,
	input  logic [`EXEC_XLEN-1:0] regValRn1,
	input  gprId_t                regIdRm,
	input  logic [`EXEC_XLEN-1:0] regValMulRes,
	input  logic [`EXEC_XLEN-1:0] memDataIn,
	input  memOk_t                memDataOK,
	output gprId_t                regIdRn2,		// fast write
	output logic [`EXEC_XLEN-1:0] regValRn2,
	output gprId_t                regIdRn4,		// held write
	output logic [`EXEC_XLEN-1:0] regValRn4,
	output logic                  exHold,
	output logic                  memFault
);

	logic [`EXEC_XLEN-1:0] ldValue;	// extended load data into EX3
	logic                  memOp;
	logic                  holdRun;
	logic                  holdExpired;

	loadExtend ldExt_i (
		.memDataIn (memDataIn),
		.opLdFmt   (opLdFmt),
		.ldValue   (ldValue)
	);

	exStage3 ex3_i (
		.clock        (clock),
		.reset        (reset),
		.opUCmd       (opUCmd),
		.opBraFlush   (opBraFlush),
		.regIdRn1     (regIdRn1),
		.regValRn1    (regValRn1),
		.regIdRm      (regIdRm),
		.regValMulRes (regValMulRes),
		.ldValue      (ldValue),
		.exHold       (exHold),
		.memFault     (memFault),
		.memOp        (memOp),
		.regIdRn2     (regIdRn2),
		.regValRn2    (regValRn2),
		.regIdRn4     (regIdRn4),
		.regValRn4    (regValRn4)
	);

	// only place the cache status gets decoded
	memWaitFsm waitFsm_i (
		.clock       (clock),
		.reset       (reset),
		.memOp       (memOp),
		.memDataOK   (memDataOK),
		.holdExpired (holdExpired),
		.exHold      (exHold),
		.memFault    (memFault),
		.holdRun     (holdRun)
	);

	holdTimer holdTmr_i (
		.clock       (clock),
		.reset       (reset),
		.holdRun     (holdRun),
		.holdExpired (holdExpired)
	);

endmodule

// File: testbench/execTailTb.sv
// execTailTb: clock, reset, random stimulus, reference model, compare tasks and timeout
`timescale 1ns/1ps
`include "exec_defines.svh"

module execTailTb
	import execPkg::*;
();

	localparam int xl = `EXEC_XLEN;
	localparam int resetCycles = 16;
	localparam int loadReps = 4;	// random words per load format
	localparam int plannedCycles = 3 * (resetCycles + 2) + 48 + 8 * loadReps + 32 + 18 + 25
		+ 41 + 2 + 6;	// sections in run order, then three idle drains
	localparam int timeoutLimit = 2 * plannedCycles;

	// model states of the memory wait FSM
	localparam int modelRun = 0;
	localparam int modelWait = 1;
	localparam int modelFaulted = 2;

	typedef struct packed {
		gprId_t          idRn2;
		logic [xl-1:0]   valRn2;
		gprId_t          idRn4;
		logic [xl-1:0]   valRn4;
	} writeExp_t;

	logic          clock = 1'b0;
	logic          reset;
	uCmd_t         opUCmd;
	loadFmt_t      opLdFmt;
	logic          opBraFlush;
	gprId_t        regIdRn1;
	logic [xl-1:0] regValRn1;
	gprId_t        regIdRm;
	logic [xl-1:0] regValMulRes;
	logic [xl-1:0] memDataIn;
	memOk_t        memDataOK;
	gprId_t        regIdRn2;
	logic [xl-1:0] regValRn2;
	gprId_t        regIdRn4;
	logic [xl-1:0] regValRn4;
	logic          exHold;
	logic          memFault;

	integer     seed = 32'hb560_4647;
	int         cycleCount = 0;
	logic       checking = 1'b0;	// off during reset
	int         refState = modelRun;
	int         refHoldCnt = 0;
	writeExp_t  writeQ[$];	// expected writes, one per driven cycle
	logic [1:0] levelQ[$];	// expected {exHold, memFault}

	execTail dut_i (
		.clock        (clock),
		.reset        (reset),
		.opUCmd       (opUCmd),
		.opLdFmt      (opLdFmt),
		.opBraFlush   (opBraFlush),
		.regIdRn1     (regIdRn1),
		.regValRn1    (regValRn1),
		.regIdRm      (regIdRm),
		.regValMulRes (regValMulRes),
		.memDataIn    (memDataIn),
		.memDataOK    (memDataOK),
		.regIdRn2     (regIdRn2),
		.regValRn2    (regValRn2),
		.regIdRn4     (regIdRn4),
		.regValRn4    (regValRn4),
		.exHold       (exHold),
		.memFault     (memFault)
	);

	always #4 clock = ~clock;	// 8 ns period

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", timeoutLimit);
			stopOnFailure();
		end
	end

	task automatic stopOnFailure;
		$display("Verification failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic checkId(input string name, input gprId_t expected, input gprId_t actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkValue(input string name, input logic [xl-1:0] expected,
		input logic [xl-1:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic compareLevels(input logic expHold, input logic expFault);
		if (exHold !== expHold || memFault !== expFault) begin
			$display("Error at %0t: exHold/memFault expected %b/%b, got %b/%b", $time,
				expHold, expFault, exHold, memFault);
			stopOnFailure();
		end
	endtask

	// narrow to the field width, then sign or zero fill
	function automatic logic [xl-1:0] extendLoad(input loadFmt_t fmt, input logic [xl-1:0] word);
		int            width;
		logic          signedFmt;
		logic [xl-1:0] mask;
		case (fmt)
			LDFMT_L, LDFMT_UL: width = 32;
			LDFMT_W, LDFMT_UW: width = 16;
			LDFMT_B, LDFMT_UB: width = 8;
			LDFMT_T48:         width = 48;
			default:           width = 64;
		endcase
		// signed formats copy the top bit of the field
		signedFmt = (fmt == LDFMT_L) || (fmt == LDFMT_W) || (fmt == LDFMT_B)
			|| (fmt == LDFMT_T48);
		if (width == 64)
			return word;
		mask = (64'd1 << width) - 64'd1;
		if (signedFmt && word[width-1])
			return word | ~mask;
		return word & mask;
	endfunction

	// expected registered writes for one cycle's inputs
	function automatic writeExp_t expectWrite(input uCmd_t cmd, input logic flush,
		input gprId_t rn1, input logic [xl-1:0] valRn1, input gprId_t rm,
		input logic [xl-1:0] mulRes, input logic [xl-1:0] loadVal, input logic stall,
		input logic fault);
		writeExp_t w;
		w = {rn1, valRn1, rn1, valRn1};	// forward on both ports
		if (cmd == UCMD_LOAD)
			w = {rm, loadVal, rm, loadVal};
		else if (cmd == UCMD_MUL3)
			w = {rm, 64'd0, rm, mulRes};	// reserve now, value on held port
		else if (cmd == UCMD_LOAD_HELD && !rm[`EXEC_GPR_PAIR_BIT])
			w = {rm, 64'd0, rm, loadVal};
		if (flush || stall || fault) begin
			w.idRn2 = `EXEC_GPR_ZZR;
			w.idRn4 = `EXEC_GPR_ZZR;
		end
		return w;
	endfunction

	task automatic advanceModel(input logic memOpNow, input memOk_t ok);
		logic okHold;
		logic okFault;
		logic expired;
		okHold = (ok == MEMOK_HOLD);
		okFault = (ok == MEMOK_FAULT);
		expired = (refHoldCnt >= `EXEC_HOLD_LIMIT);
		if (refState == modelWait)
			refHoldCnt = (refHoldCnt == 15) ? 15 : refHoldCnt + 1;	// saturating
		else
			refHoldCnt = 0;
		if (refState == modelRun && memOpNow && okFault)
			refState = modelFaulted;
		else if (refState == modelRun && memOpNow && okHold)
			refState = modelWait;
		else if (refState == modelWait && ((memOpNow && okFault) || expired))
			refState = modelFaulted;	// hard fault or hold too long
		else if (refState == modelWait && !okHold)
			refState = modelRun;
	endtask

	task automatic idleInputs;
		opUCmd <= UCMD_NOP;
		opLdFmt <= LDFMT_Q;
		opBraFlush <= 1'b0;
		regIdRn1 <= `EXEC_GPR_ZZR;
		regValRn1 <= '0;
		regIdRm <= `EXEC_GPR_ZZR;
		regValMulRes <= '0;
		memDataIn <= '0;
		memDataOK <= MEMOK_READY;
	endtask

	task automatic driveCycle(input uCmd_t cmd, input loadFmt_t fmt, input logic flush,
		input gprId_t rn1, input logic [xl-1:0] valRn1, input gprId_t rm,
		input logic [xl-1:0] mulRes, input logic [xl-1:0] word, input memOk_t ok);
		logic memOpNow;
		logic stall;
		logic fault;
		@(posedge clock);
		opUCmd <= cmd;
		opLdFmt <= fmt;
		opBraFlush <= flush;
		regIdRn1 <= rn1;
		regValRn1 <= valRn1;
		regIdRm <= rm;
		regValMulRes <= mulRes;
		memDataIn <= word;
		memDataOK <= ok;
		memOpNow = (cmd == UCMD_LOAD) || (cmd == UCMD_LOAD_HELD) || (cmd == UCMD_STORE);
		fault = (refState == modelFaulted);
		stall = memOpNow && (ok == MEMOK_HOLD) && !fault;
		levelQ.push_back({stall, fault});
		writeQ.push_back(expectWrite(cmd, flush, rn1, valRn1, rm, mulRes,
			extendLoad(fmt, word), stall, fault));
		advanceModel(memOpNow, ok);
	endtask

	// one idle cycle so the last driven write still gets compared
	task automatic drainChecks;
		driveCycle(UCMD_NOP, LDFMT_Q, 1'b0, `EXEC_GPR_ZZR, '0, `EXEC_GPR_ZZR, '0, '0,
			MEMOK_READY);
		@(posedge clock);
	endtask

	function automatic logic [xl-1:0] randomWord();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic gprId_t randomId();
		logic [31:0] r;
		r = $random(seed);
		return r[6:0];
	endfunction

	function automatic uCmd_t randomCmd();
		logic [31:0] r;
		r = $random(seed);
		return uCmd_t'(3'(r % 32'd6));
	endfunction

	// pairSel 0 or 1 forces the pair bit of Rm, anything else leaves it random
	task automatic randomCycle(input uCmd_t cmd, input loadFmt_t fmt, input logic flush,
		input memOk_t ok, input int pairSel);
		gprId_t rm;
		rm = randomId();
		if (pairSel == 0 || pairSel == 1)
			rm[`EXEC_GPR_PAIR_BIT] = pairSel[0];
		driveCycle(cmd, fmt, flush, randomId(), randomWord(), rm, randomWord(), randomWord(), ok);
	endtask

	task automatic applyReset;
		checking = 1'b0;
		@(posedge clock);
		reset <= 1'b1;
		idleInputs();
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		refState = modelRun;
		refHoldCnt = 0;
		writeQ.delete();
		levelQ.delete();
		@(negedge clock);
		checkId("regIdRn2", `EXEC_GPR_ZZR, regIdRn2);
		checkValue("regValRn2", '0, regValRn2);
		checkId("regIdRn4", `EXEC_GPR_ZZR, regIdRn4);
		checkValue("regValRn4", '0, regValRn4);
		compareLevels(1'b0, 1'b0);
		checking = 1'b1;
	endtask

	// levels of the current inputs, writes of the previous cycle's inputs
	always @(negedge clock) begin : compareOutputs
		writeExp_t  due;
		logic [1:0] lv;
		if (checking && levelQ.size() > 0) begin
			lv = levelQ.pop_front();
			compareLevels(lv[1], lv[0]);
		end
		if (checking && writeQ.size() > 1) begin
			due = writeQ.pop_front();
			checkId("regIdRn2", due.idRn2, regIdRn2);
			checkId("regIdRn4", due.idRn4, regIdRn4);
			if (due.idRn2 != `EXEC_GPR_ZZR)	// value ignored when nothing is written
				checkValue("regValRn2", due.valRn2, regValRn2);
			if (due.idRn4 != `EXEC_GPR_ZZR)
				checkValue("regValRn4", due.valRn4, regValRn4);
		end
	end

	initial begin : runTests
		gprId_t        rn1;
		gprId_t        rm;
		logic [xl-1:0] val;
		logic [xl-1:0] word;
		loadFmt_t      fmt;
		int            holdLen;
		reset <= 1'b1;
		idleInputs();
		applyReset();
		for (int i = 0; i < 40; i++)	// plain forwarding
			randomCycle((i % 2) ? UCMD_ALU : UCMD_NOP, LDFMT_Q, 1'b0, MEMOK_READY, 2);
		for (int i = 0; i < 8; i++)	// code 01 must act as ready
			randomCycle(UCMD_STORE, LDFMT_Q, 1'b0, (i % 2) ? memOk_t'(2'b01) : MEMOK_READY, 2);
		for (int f = 0; f < 8; f++)
			for (int r = 0; r < loadReps; r++)
				randomCycle(UCMD_LOAD, loadFmt_t'(f[2:0]), 1'b0, MEMOK_READY, 2);
		for (int i = 0; i < 12; i++)
			randomCycle(UCMD_MUL3, LDFMT_Q, 1'b0, MEMOK_READY, 2);
		for (int i = 0; i < 12; i++)
			randomCycle(UCMD_LOAD_HELD, loadFmt_t'(i[2:0]), 1'b0, MEMOK_READY, 0);
		for (int i = 0; i < 8; i++)	// paired dest keeps the forward
			randomCycle(UCMD_LOAD_HELD, LDFMT_W, 1'b0, MEMOK_READY, 1);
		for (int c = 0; c < 6; c++)
			for (int r = 0; r < 3; r++)
				randomCycle(uCmd_t'(c[2:0]), LDFMT_B, 1'b1, MEMOK_READY, 2);
		// short holds, inputs kept steady until the stall ends
		for (int round = 0; round < 3; round++) begin
			holdLen = (round == 0) ? 3 : (round == 1) ? 6 : 10;
			fmt = (round == 0) ? LDFMT_B : (round == 1) ? LDFMT_UL : LDFMT_T48;
			rn1 = randomId();
			val = randomWord();
			rm = randomId();
			word = randomWord();
			repeat (holdLen)
				driveCycle(UCMD_LOAD, fmt, 1'b0, rn1, val, rm, '0, word, MEMOK_HOLD);
			driveCycle(UCMD_LOAD, fmt, 1'b0, rn1, val, rm, '0, word, MEMOK_READY);
			randomCycle(UCMD_NOP, LDFMT_Q, 1'b0, MEMOK_READY, 2);
		end
		// hold past the limit, then the fault sticks
		rm = randomId();
		word = randomWord();
		repeat (20)
			driveCycle(UCMD_LOAD, LDFMT_Q, 1'b0, randomId(), '0, rm, '0, word, MEMOK_HOLD);
		repeat (10)
			randomCycle(randomCmd(), LDFMT_L, 1'b0, MEMOK_READY, 2);
		drainChecks();
		applyReset();
		randomCycle(UCMD_STORE, LDFMT_Q, 1'b0, MEMOK_FAULT, 2);
		repeat (10)
			randomCycle(randomCmd(), LDFMT_UW, 1'b0, memOk_t'(2'(randomId())), 2);
		drainChecks();
		applyReset();
		randomCycle(UCMD_ALU, LDFMT_Q, 1'b0, MEMOK_READY, 2);
		randomCycle(UCMD_NOP, LDFMT_Q, 1'b0, MEMOK_READY, 2);
		drainChecks();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hw
hw/execPkg.sv
hw/loadExtend.sv
hw/holdTimer.sv
hw/memWaitFsm.sv
hw/exStage3.sv
hw/execTail.sv
testbench/execTailTb.sv

// File: Makefile
# Verilator build and run of the execute back end testbench

SIM  := obj_dir/VexecTailTb
SRCS := $(filter-out +%,$(shell cat vlog.f)) hw/exec_defines.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module execTailTb -o VexecTailTb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Verification passed" sim.log || { echo "no pass message in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
